// ==== hdl/exec_pkg.sv ====
/*
  Shared execute-stage definitions: operation and size codes, the
  64-bit operand union, flag bit positions, request and writeback bundles
*/
`default_nettype none

package exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_ADC   = 4'd1,
        ALU_SUB   = 4'd2,
        ALU_CMP   = 4'd3,
        ALU_AND   = 4'd4,
        ALU_OR    = 4'd5,
        ALU_XOR   = 4'd6,
        ALU_PADDW = 4'd7,
        ALU_PASSB = 4'd8,
        ALU_JCC   = 4'd9
    } alu_op_e;

    // Qword only valid for packed add and pass B
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2,
        SZ_QWORD = 2'd3
    } opsize_e;

    // Scalar view or four 16-bit lanes
    typedef union packed {
        logic [63:0]      scalar;
        logic [3:0][15:0] lane;
    } operand_u;

    // Bit positions in the 7-bit flags word
    localparam int FLAG_CF = 0;
    localparam int FLAG_PF = 1;
    localparam int FLAG_AF = 2;
    localparam int FLAG_ZF = 3;
    localparam int FLAG_SF = 4;
    localparam int FLAG_OF = 5;
    localparam int FLAG_DF = 6;

    typedef struct packed {
        alu_op_e     alu_op;
        opsize_e     opsize;
        logic [3:0]  cond;
        operand_u    op_a;
        operand_u    op_b;
        logic [31:0] pc;
        logic        branch_taken;
        logic        set_d_flag;
        logic        clear_d_flag;
        logic [2:0]  dest_reg;
        logic [31:0] dest_address;
    } exec_req_t;

    typedef struct packed {
        logic [63:0] result;
        opsize_e     opsize;
        alu_op_e     alu_op;
        logic [2:0]  dest_reg;
        logic [31:0] dest_address;
        logic [31:0] pc;
        // As predicted by decode
        logic        branch_taken;
        logic        jump_load_address;
        logic [31:0] jump_address;
        logic        br_misprediction;
    } wb_t;

endpackage

`default_nettype wire

// ==== hdl/exec_alu.sv ====
/*
  Single-pass ALU: sized add/adc/sub/cmp, logic ops, packed-word add,
  pass B; produces result, new flag values and flag update mask
*/
`timescale 1ns/1ns
`default_nettype none

module exec_alu (
    input  exec_pkg::exec_req_t req,
    input  logic [6:0]          flags,
    output logic [63:0]         result,
    output logic [5:0]          flag_value,
    output logic [5:0]          flag_mask
);

    localparam logic [5:0] ARITH_MASK = 6'b11_1111;
    localparam logic [5:0] LOGIC_MASK = (6'd1 << exec_pkg::FLAG_CF) |
                                        (6'd1 << exec_pkg::FLAG_PF) |
                                        (6'd1 << exec_pkg::FLAG_ZF) |
                                        (6'd1 << exec_pkg::FLAG_SF) |
                                        (6'd1 << exec_pkg::FLAG_OF);

    logic [63:0]        size_mask;
    logic [5:0]         msb;
    logic [6:0]         carry_pos;
    logic [63:0]        a_m;
    logic [63:0]        b_m;
    logic               carry_in;
    logic [64:0]        add_raw;
    logic [64:0]        sub_raw;
    logic [64:0]        raw;
    logic [63:0]        flag_res;
    logic               is_arith;
    logic               is_logic;
    logic               is_sub;
    exec_pkg::operand_u lane_sum;

    always_comb begin
        case (req.opsize)
            exec_pkg::SZ_BYTE: begin
                size_mask = 64'h0000_0000_0000_00ff;
                msb = 6'd7;
            end
            exec_pkg::SZ_WORD: begin
                size_mask = 64'h0000_0000_0000_ffff;
                msb = 6'd15;
            end
            exec_pkg::SZ_DWORD: begin
                size_mask = 64'h0000_0000_ffff_ffff;
                msb = 6'd31;
            end
            default: begin
                size_mask = 64'hffff_ffff_ffff_ffff;
                msb = 6'd63;
            end
        endcase
    end

    assign carry_pos = {1'b0, msb} + 7'd1;
    assign a_m = req.op_a.scalar & size_mask;
    assign b_m = req.op_b.scalar & size_mask;
    assign carry_in = (req.alu_op == exec_pkg::ALU_ADC) && flags[exec_pkg::FLAG_CF];

    // Extra top bit catches carry out or borrow at any size
    assign add_raw = {1'b0, a_m} + {1'b0, b_m} + {64'd0, carry_in};
    assign sub_raw = {1'b0, a_m} - {1'b0, b_m};

    // Lanes wrap independently
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_sum.lane[i] = req.op_a.lane[i] + req.op_b.lane[i];
        end
    end

    always_comb begin
        raw = '0;
        result = '0;
        is_arith = 1'b0;
        is_logic = 1'b0;
        is_sub = 1'b0;
        case (req.alu_op)
            exec_pkg::ALU_ADD, exec_pkg::ALU_ADC: begin
                raw = add_raw;
                is_arith = 1'b1;
                result = add_raw[63:0] & size_mask;
            end
            exec_pkg::ALU_SUB: begin
                raw = sub_raw;
                is_arith = 1'b1;
                is_sub = 1'b1;
                result = sub_raw[63:0] & size_mask;
            end
            exec_pkg::ALU_CMP: begin
                raw = sub_raw;
                is_arith = 1'b1;
                is_sub = 1'b1;
                result = a_m;
            end
            exec_pkg::ALU_AND: begin
                is_logic = 1'b1;
                result = a_m & b_m;
            end
            exec_pkg::ALU_OR: begin
                is_logic = 1'b1;
                result = a_m | b_m;
            end
            exec_pkg::ALU_XOR: begin
                is_logic = 1'b1;
                result = a_m ^ b_m;
            end
            exec_pkg::ALU_PADDW: result = lane_sum.scalar & size_mask;
            exec_pkg::ALU_PASSB: result = b_m;
            // Jump carries no data result
            default: result = '0;
        endcase
    end

    // Compare takes its flags from the difference, not from the result
    assign flag_res = is_arith ? (raw[63:0] & size_mask) : result;

    always_comb begin
        flag_value = '0;
        flag_value[exec_pkg::FLAG_ZF] = (flag_res == 64'd0);
        flag_value[exec_pkg::FLAG_SF] = flag_res[msb];
        flag_value[exec_pkg::FLAG_PF] = ~^flag_res[7:0];
        if (is_arith) begin
            flag_value[exec_pkg::FLAG_CF] = raw[carry_pos];
            flag_value[exec_pkg::FLAG_AF] = a_m[4] ^ b_m[4] ^ raw[4];
            if (is_sub) begin
                flag_value[exec_pkg::FLAG_OF] = (a_m[msb] != b_m[msb]) && (raw[msb] != a_m[msb]);
            end else begin
                flag_value[exec_pkg::FLAG_OF] = (a_m[msb] == b_m[msb]) && (raw[msb] != a_m[msb]);
            end
        end
        if (is_arith) begin
            flag_mask = ARITH_MASK;
        end else if (is_logic) begin
            flag_mask = LOGIC_MASK;
        end else begin
            flag_mask = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exec_branch.sv ====
/*
  Conditional jump evaluation against the flags: direction, target
  and misprediction against the decoder's prediction
*/
`timescale 1ns/1ns
`default_nettype none

module exec_branch (
    input  exec_pkg::exec_req_t req,
    input  logic [6:0]          flags,
    output logic                jump_load_address,
    output logic [31:0]         jump_address,
    output logic                br_misprediction
);

    logic is_jcc;
    logic cf;
    logic pf;
    logic zf;
    logic sf;
    logic of;
    logic base_true;
    logic taken;

    assign is_jcc = (req.alu_op == exec_pkg::ALU_JCC);
    assign cf = flags[exec_pkg::FLAG_CF];
    assign pf = flags[exec_pkg::FLAG_PF];
    assign zf = flags[exec_pkg::FLAG_ZF];
    assign sf = flags[exec_pkg::FLAG_SF];
    assign of = flags[exec_pkg::FLAG_OF];

    // Even codes test the condition, odd codes its negation
    always_comb begin
        case (req.cond[3:1])
            3'd0: base_true = of;
            3'd1: base_true = cf;
            3'd2: base_true = zf;
            3'd3: base_true = cf | zf;
            3'd4: base_true = sf;
            3'd5: base_true = pf;
            3'd6: base_true = sf ^ of;
            default: base_true = zf | (sf ^ of);
        endcase
    end

    assign taken = is_jcc & (base_true ^ req.cond[0]);

    assign jump_load_address = taken;
    assign jump_address = is_jcc ? (req.pc + req.op_b.scalar[31:0]) : 32'd0;
    assign br_misprediction = is_jcc & (taken != req.branch_taken);

endmodule

`default_nettype wire

// ==== hdl/eflags_reg.sv ====
/*
  Flags register, six arithmetic flags loaded under mask plus the
  direction flag with set and clear
*/
`timescale 1ns/1ns
`default_nettype none

module eflags_reg (
    input  logic       clk,
    input  logic       rst,
    input  logic       accept,
    input  logic [5:0] flag_value,
    input  logic [5:0] flag_mask,
    input  logic       set_d_flag,
    input  logic       clear_d_flag,
    output logic [6:0] flags
);

    logic [5:0] arith_next;

    // Unmasked flags keep their old value
    assign arith_next = (flags[5:0] & ~flag_mask) | (flag_value & flag_mask);

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (accept) begin
            flags[5:0] <= arith_next;
            // Set wins over clear
            if (set_d_flag) begin
                flags[exec_pkg::FLAG_DF] <= 1'b1;
            end else if (clear_d_flag) begin
                flags[exec_pkg::FLAG_DF] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exec_pipestage.sv ====
/*
  One-entry valid/ready register stage with flush
*/
`timescale 1ns/1ns
`default_nettype none

module exec_pipestage #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             accept
);

    // Empty, or the held entry leaves this cycle
    assign in_ready = ~flush & (~out_valid | out_ready);
    assign accept = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/execute_top.sv ====
/*
  Execute stage top: ALU, branch unit, flags register and the
  output pipestage toward writeback
*/
`timescale 1ns/1ns
`default_nettype none

module execute_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                e_valid,
    output logic                e_ready,
    input  exec_pkg::exec_req_t e_req,
    output logic                wb_valid,
    input  logic                wb_ready,
    output exec_pkg::wb_t       wb,
    output logic [6:0]          eflags_out
);

    localparam int WB_WIDTH = $bits(exec_pkg::wb_t);

    logic [63:0]   alu_result;
    logic [5:0]    flag_value;
    logic [5:0]    flag_mask;
    logic          jump_load_address;
    logic [31:0]   jump_address;
    logic          br_misprediction;
    logic          accept;
    exec_pkg::wb_t wb_in;

    exec_alu u_alu (
        .req        (e_req),
        .flags      (eflags_out),
        .result     (alu_result),
        .flag_value (flag_value),
        .flag_mask  (flag_mask)
    );

    exec_branch u_branch (
        .req               (e_req),
        .flags             (eflags_out),
        .jump_load_address (jump_load_address),
        .jump_address      (jump_address),
        .br_misprediction  (br_misprediction)
    );

    // Flags commit when the stage accepts the operation
    eflags_reg u_eflags (
        .clk          (clk),
        .rst          (rst),
        .accept       (accept),
        .flag_value   (flag_value),
        .flag_mask    (flag_mask),
        .set_d_flag   (e_req.set_d_flag),
        .clear_d_flag (e_req.clear_d_flag),
        .flags        (eflags_out)
    );

    assign wb_in.result = alu_result;
    assign wb_in.opsize = e_req.opsize;
    assign wb_in.alu_op = e_req.alu_op;
    assign wb_in.dest_reg = e_req.dest_reg;
    assign wb_in.dest_address = e_req.dest_address;
    assign wb_in.pc = e_req.pc;
    assign wb_in.branch_taken = e_req.branch_taken;
    assign wb_in.jump_load_address = jump_load_address;
    assign wb_in.jump_address = jump_address;
    assign wb_in.br_misprediction = br_misprediction;

    exec_pipestage #(
        .WIDTH (WB_WIDTH)
    ) u_pipestage (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (e_valid),
        .in_ready  (e_ready),
        .in_data   (wb_in),
        .out_valid (wb_valid),
        .out_ready (wb_ready),
        .out_data  (wb),
        .accept    (accept)
    );

endmodule

`default_nettype wire

// ==== testbench/execute_top_properties.sv ====
/*
  Bound assertions on the execute stage output handshake and flush
*/
`timescale 1ns/1ns
`default_nettype none

module execute_top_properties (
    input logic          clk,
    input logic          rst,
    input logic          flush,
    input logic          e_ready,
    input logic          wb_valid,
    input logic          wb_ready,
    input exec_pkg::wb_t wb
);

    // Stalled output holds its data
    assert property (@(posedge clk)
        (wb_valid && !wb_ready && !flush && !rst) |=> (wb_valid && $stable(wb)))
        else $error("wb changed or dropped while stalled");

    assert property (@(posedge clk) (flush || rst) |=> !wb_valid)
        else $error("wb_valid high after flush or reset");

    assert property (@(posedge clk) flush |-> !e_ready)
        else $error("e_ready high during flush");

endmodule

bind execute_top execute_top_properties u_properties (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .e_ready  (e_ready),
    .wb_valid (wb_valid),
    .wb_ready (wb_ready),
    .wb       (wb)
);

`default_nettype wire

// ==== testbench/tb_execute_top.sv ====
/*
  Execute stage testbench: clock and reset, LFSR stimulus, reference
  model with expected queue, checking process, timeout and result lines
*/
`timescale 1ns/1ns
`default_nettype none

module tb_execute_top;

    localparam int N_SCALAR = 60;
    localparam int N_PADD = 20;
    localparam int N_JUMP = 30;
    localparam int N_MIXED = 80;
    localparam int TOTAL_TXN = N_SCALAR + N_PADD + 2 * N_JUMP + N_MIXED + 1;
    localparam int CYCLE_LIMIT = 2 * TOTAL_TXN + 200;

    localparam int KIND_SCALAR = 0;
    localparam int KIND_PADD = 1;
    localparam int KIND_JUMP = 2;
    localparam int KIND_MIXED = 3;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                e_valid;
    logic                e_ready;
    exec_pkg::exec_req_t e_req;
    logic                wb_valid;
    logic                wb_ready;
    exec_pkg::wb_t       wb;
    logic [6:0]          eflags_out;

    logic [15:0]   lfsr_state;
    logic          bp_mode;
    logic [6:0]    model_flags;
    logic [6:0]    next_flags;
    exec_pkg::wb_t exp_q[$];
    exec_pkg::wb_t model_item;
    exec_pkg::wb_t expect_item;
    int            error_count = 0;
    int            accepted_count = 0;
    int            checked_count = 0;
    int            dropped_count = 0;
    int            cycle_count = 0;
    int            errors_before;
    int            drops_before;

    execute_top u_execute_top (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .e_valid    (e_valid),
        .e_ready    (e_ready),
        .e_req      (e_req),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb         (wb),
        .eflags_out (eflags_out)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Expected writeback and the flags after the operation
    function automatic exec_pkg::wb_t ref_exec(
        input  exec_pkg::exec_req_t req,
        input  logic [6:0]          fin,
        output logic [6:0]          fout
    );
        exec_pkg::wb_t w;
        int            n;
        int            i;
        logic [63:0]   mask;
        logic [63:0]   a;
        logic [63:0]   b;
        logic [63:0]   r;
        logic          c;
        logic          taken;
        logic          sets_szp;
        logic          cf;
        logic          pf;
        logic          zf;
        logic          sf;
        logic          of;
        w = '0;
        fout = fin;
        r = '0;
        c = 1'b0;
        taken = 1'b0;
        sets_szp = 1'b1;
        cf = fin[exec_pkg::FLAG_CF];
        pf = fin[exec_pkg::FLAG_PF];
        zf = fin[exec_pkg::FLAG_ZF];
        sf = fin[exec_pkg::FLAG_SF];
        of = fin[exec_pkg::FLAG_OF];
        case (req.opsize)
            exec_pkg::SZ_BYTE: n = 8;
            exec_pkg::SZ_WORD: n = 16;
            exec_pkg::SZ_DWORD: n = 32;
            default: n = 64;
        endcase
        mask = (n == 64) ? {64{1'b1}} : ((64'd1 << n) - 64'd1);
        a = req.op_a.scalar & mask;
        b = req.op_b.scalar & mask;
        case (req.alu_op)
            exec_pkg::ALU_ADD, exec_pkg::ALU_ADC: begin
                c = (req.alu_op == exec_pkg::ALU_ADC) ? cf : 1'b0;
                r = (a + b + {63'd0, c}) & mask;
                w.result = r;
                // Wrapped sum below a means a carry out
                fout[exec_pkg::FLAG_CF] = (r < a) || (c && (r == a));
                fout[exec_pkg::FLAG_AF] = ({1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, c}) > 5'd15;
                fout[exec_pkg::FLAG_OF] = (a[n-1] == b[n-1]) && (r[n-1] != a[n-1]);
            end
            exec_pkg::ALU_SUB, exec_pkg::ALU_CMP: begin
                r = (a - b) & mask;
                w.result = (req.alu_op == exec_pkg::ALU_CMP) ? a : r;
                fout[exec_pkg::FLAG_CF] = a < b;
                fout[exec_pkg::FLAG_AF] = a[3:0] < b[3:0];
                fout[exec_pkg::FLAG_OF] = (a[n-1] != b[n-1]) && (r[n-1] != a[n-1]);
            end
            exec_pkg::ALU_AND, exec_pkg::ALU_OR, exec_pkg::ALU_XOR: begin
                if (req.alu_op == exec_pkg::ALU_AND) begin
                    r = a & b;
                end else if (req.alu_op == exec_pkg::ALU_OR) begin
                    r = a | b;
                end else begin
                    r = a ^ b;
                end
                w.result = r;
                fout[exec_pkg::FLAG_CF] = 1'b0;
                fout[exec_pkg::FLAG_OF] = 1'b0;
            end
            exec_pkg::ALU_PADDW: begin
                for (i = 0; i < 4; i++) begin
                    r[16*i +: 16] = req.op_a.lane[i] + req.op_b.lane[i];
                end
                w.result = r & mask;
                sets_szp = 1'b0;
            end
            exec_pkg::ALU_PASSB: begin
                w.result = b;
                sets_szp = 1'b0;
            end
            default: begin
                case (req.cond)
                    4'h0: taken = of;
                    4'h1: taken = !of;
                    4'h2: taken = cf;
                    4'h3: taken = !cf;
                    4'h4: taken = zf;
                    4'h5: taken = !zf;
                    4'h6: taken = cf || zf;
                    4'h7: taken = !cf && !zf;
                    4'h8: taken = sf;
                    4'h9: taken = !sf;
                    4'ha: taken = pf;
                    4'hb: taken = !pf;
                    4'hc: taken = sf != of;
                    4'hd: taken = sf == of;
                    4'he: taken = zf || (sf != of);
                    default: taken = !zf && (sf == of);
                endcase
                w.jump_load_address = taken;
                w.jump_address = req.pc + req.op_b.scalar[31:0];
                w.br_misprediction = taken != req.branch_taken;
                sets_szp = 1'b0;
            end
        endcase
        if (sets_szp) begin
            fout[exec_pkg::FLAG_ZF] = (r == 64'd0);
            fout[exec_pkg::FLAG_SF] = r[n-1];
            fout[exec_pkg::FLAG_PF] = ~^r[7:0];
        end
        if (req.set_d_flag) begin
            fout[exec_pkg::FLAG_DF] = 1'b1;
        end else if (req.clear_d_flag) begin
            fout[exec_pkg::FLAG_DF] = 1'b0;
        end
        w.opsize = req.opsize;
        w.alu_op = req.alu_op;
        w.dest_reg = req.dest_reg;
        w.dest_address = req.dest_address;
        w.pc = req.pc;
        w.branch_taken = req.branch_taken;
        return w;
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    task automatic make_req(input int kind, output exec_pkg::exec_req_t req);
        logic [63:0] v;
        int          k;
        k = kind;
        req = '0;
        if (k == KIND_MIXED) begin
            rand_bits(2, v);
            k = (v[1:0] == 2'd3) ? KIND_JUMP : ((v[1:0] == 2'd2) ? KIND_PADD : KIND_SCALAR);
        end
        rand_bits(64, v);
        req.op_a.scalar = v;
        rand_bits(64, v);
        req.op_b.scalar = v;
        rand_bits(32, v);
        req.pc = v[31:0];
        rand_bits(32, v);
        req.dest_address = v[31:0];
        rand_bits(3, v);
        req.dest_reg = v[2:0];
        rand_bits(4, v);
        req.cond = v[3:0];
        rand_bits(1, v);
        req.branch_taken = v[0];
        rand_bits(3, v);
        req.set_d_flag = (v[2:0] == 3'd0) || (v[2:0] == 3'd2);
        req.clear_d_flag = (v[2:0] == 3'd1) || (v[2:0] == 3'd2);
        if (k == KIND_SCALAR) begin
            rand_bits(3, v);
            req.alu_op = (v[2:0] == 3'd7) ? exec_pkg::ALU_PASSB
                                           : exec_pkg::alu_op_e'({1'b0, v[2:0]});
            rand_bits(2, v);
            req.opsize = (v[1:0] == 2'd3) ? exec_pkg::SZ_DWORD : exec_pkg::opsize_e'(v[1:0]);
            rand_bits(2, v);
            // Equal operands reach the zero flag
            if (v[1:0] == 2'd0) begin
                req.op_b = req.op_a;
            end
        end else if (k == KIND_PADD) begin
            req.alu_op = exec_pkg::ALU_PADDW;
            req.opsize = exec_pkg::SZ_QWORD;
        end else begin
            req.alu_op = exec_pkg::ALU_JCC;
            req.opsize = exec_pkg::SZ_DWORD;
        end
    endtask

    task automatic next_cycle();
        logic [63:0] v;
        @(posedge clk);
        #1;
        if (bp_mode) begin
            rand_bits(2, v);
            wb_ready = (v[1:0] != 2'd0);
        end
    endtask

    task automatic send_op(input exec_pkg::exec_req_t req);
        logic hit;
        e_req = req;
        e_valid = 1'b1;
        hit = 1'b0;
        while (!hit) begin
            @(negedge clk);
            hit = e_ready;
            next_cycle();
        end
        e_valid = 1'b0;
    endtask

    task automatic run_ops(input int kind, input int count);
        exec_pkg::exec_req_t req;
        logic [63:0]         v;
        int                  i;
        for (i = 0; i < count; i++) begin
            if (bp_mode) begin
                rand_bits(4, v);
                if (v[3:0] == 4'd0) begin
                    flush = 1'b1;
                    next_cycle();
                    flush = 1'b0;
                end else if (v[1:0] == 2'd1) begin
                    next_cycle();
                end
            end
            // A flag-setting operation ahead of each jump
            if (kind == KIND_JUMP) begin
                make_req(KIND_SCALAR, req);
                send_op(req);
            end
            make_req(kind, req);
            send_op(req);
        end
    endtask

    task automatic finish_test(input string name);
        wb_ready = 1'b1;
        while (exp_q.size() != 0 || wb_valid) begin
            next_cycle();
        end
        $display("test %s: %0d errors", name, error_count - errors_before);
    endtask

    // Flags, output transfers, then new expectations
    always @(negedge clk) begin
        if (rst) begin
            model_flags = '0;
            exp_q.delete();
        end else begin
            if (eflags_out !== model_flags) begin
                $display("error at %0t: eflags %b, expected %b", $time, eflags_out, model_flags);
                error_count = error_count + 1;
            end
            if (wb_valid && (flush || wb_ready)) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected writeback transfer at %0t with nothing outstanding",
                             $time);
                    error_count = error_count + 1;
                end else begin
                    expect_item = exp_q.pop_front();
                    if (flush) begin
                        dropped_count = dropped_count + 1;
                    end else begin
                        checked_count = checked_count + 1;
                        if (wb.result !== expect_item.result) begin
                            $display("error at %0t: result %h, expected %h (op %0d size %0d)",
                                     $time, wb.result, expect_item.result,
                                     expect_item.alu_op, expect_item.opsize);
                            error_count = error_count + 1;
                        end
                        if (wb !== expect_item) begin
                            $display("error at %0t: writeback %h, expected %h",
                                     $time, wb, expect_item);
                            error_count = error_count + 1;
                        end
                    end
                end
            end
            if (e_valid && e_ready) begin
                model_item = ref_exec(e_req, model_flags, next_flags);
                exp_q.push_back(model_item);
                model_flags = next_flags;
                accepted_count = accepted_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        e_valid = 1'b0;
        e_req = '0;
        wb_ready = 1'b1;
        bp_mode = 1'b0;
        lfsr_state = 16'd56;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        errors_before = error_count;
        @(negedge clk);
        if (wb_valid !== 1'b0 || e_ready !== 1'b1 || eflags_out !== 7'd0) begin
            $display("error at %0t: after reset wb_valid %b e_ready %b eflags %b",
                     $time, wb_valid, e_ready, eflags_out);
            error_count = error_count + 1;
        end
        next_cycle();
        finish_test("reset_state");

        errors_before = error_count;
        run_ops(KIND_SCALAR, N_SCALAR);
        finish_test("scalar_ops");

        errors_before = error_count;
        run_ops(KIND_PADD, N_PADD);
        finish_test("packed_add");

        errors_before = error_count;
        run_ops(KIND_JUMP, N_JUMP);
        finish_test("cond_jumps");

        errors_before = error_count;
        bp_mode = 1'b1;
        run_ops(KIND_MIXED, N_MIXED);
        bp_mode = 1'b0;
        finish_test("backpressure_flush");

        // Held item under a stalled writeback is flushed
        errors_before = error_count;
        drops_before = dropped_count;
        wb_ready = 1'b0;
        make_req(KIND_SCALAR, e_req);
        send_op(e_req);
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        @(negedge clk);
        if (wb_valid !== 1'b0 || dropped_count != drops_before + 1) begin
            $display("flush at %0t did not drop the held operation", $time);
            error_count = error_count + 1;
        end
        finish_test("flush_held");

        $display("accepted %0d, checked %0d, dropped %0d, errors %0d",
                 accepted_count, checked_count, dropped_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_branch.sv
hdl/eflags_reg.sv
hdl/exec_pipestage.sv
hdl/execute_top.sv
testbench/execute_top_properties.sv
testbench/tb_execute_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the execute stage testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_execute_top -f project.f \
    -o sim_execute_top \
    && ./obj_dir/sim_execute_top > sim.log 2>&1 \
    || echo "simulation did not complete" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && echo "simulation failed" && exit 1
grep -q "RESULT: PASS" sim.log || { echo "simulation failed"; exit 1; }
echo "simulation passed"
